//--- src/dac_params.svh
// nanoDAC controller constants
// register offsets, version, reset word and sclk timing
`ifndef DAC_PARAMS_SVH
`define DAC_PARAMS_SVH

// register bus address width
`define DAC_ADDR_W 2

// register offsets, one 16-bit word each
`define DAC_ADDR_VERSION 2'd0
`define DAC_ADDR_WORD 2'd1
`define DAC_ADDR_EN 2'd2
`define DAC_NUM_REGS 3

`define DAC_MODULE_VERSION 16'h0001

// mode 01, data 0, sent once after reset
`define DAC_DEFAULT_WORD 16'h4000

// clk cycles per sclk half period
`define DAC_SCLK_HALF 2

`endif

//--- src/mmi_pkg.sv
// register bus types
// request and response bundles between the bus master and the register map
`default_nettype none

`include "dac_params.svh"

package mmi_pkg;

    // master to register map
    typedef struct packed {
        logic                   wvalid;
        logic [`DAC_ADDR_W-1:0] waddr;
        logic [15:0]            wdata;
        logic                   arvalid;
        logic [`DAC_ADDR_W-1:0] raddr;
        logic                   rready;
    } mmi_req_t;

    // register map to master
    typedef struct packed {
        logic        wready;
        // pulses in the cycle the read data appears
        logic        arready;
        logic        rvalid;
        logic [15:0] rdata;
    } mmi_rsp_t;

endpackage

`default_nettype wire

//--- src/dac_pkg.sv
// nanoDAC word types
// field layout of the 16-bit DAC frame and the transfer request
`default_nettype none

package dac_pkg;

    // power modes in bits 15..14
    typedef enum logic [1:0] {
        DAC_MODE_NORMAL   = 2'b00,
        DAC_MODE_PD_1K    = 2'b01,
        DAC_MODE_PD_100K  = 2'b10,
        DAC_MODE_TRISTATE = 2'b11
    } dac_mode_t;

    typedef struct packed {
        dac_mode_t   mode;
        logic [7:0]  data;
        // ignored by the DAC
        logic [5:0]  rsvd;
    } dac_fields_t;

    // raw view feeds the shifter, field view is used for the gain merge
    typedef union packed {
        logic [15:0] raw;
        dac_fields_t fields;
    } dac_word_u;

    // one transfer request, stb is a single-cycle pulse
    typedef struct packed {
        logic      stb;
        dac_word_u word;
    } dac_xfer_t;

endpackage

`default_nettype wire

//--- src/dac_reg_map.sv
// nanoDAC register map
// decodes bus reads and writes and gain strobes into DAC transfer requests
`timescale 1ns/1ps
`default_nettype none

`include "dac_params.svh"

module dac_reg_map (
    input  var logic               clk_ifc,
    input  var logic               SET_DEFAULT_ON_RESET,
    input  var mmi_pkg::mmi_req_t  mmi_req,
    output mmi_pkg::mmi_rsp_t      mmi_rsp,
    input  var logic               en_mmi_ctrl,
    input  var logic [7:0]         gain,
    input  var logic               gain_stb,
    output dac_pkg::dac_xfer_t     xfer_req
);

    ////////////////////////////////////////////////////////////
    // register state

    dac_pkg::dac_word_u dac_word_q;
    logic               en_q;

    logic               wready_q;
    logic               arready_q;
    logic               rvalid_q;
    logic [15:0]        rdata_q;

    logic               req_stb_q;
    dac_pkg::dac_word_u req_word_q;

    logic               write_hit;
    logic               read_accept;
    dac_pkg::dac_word_u gain_word;
    logic [15:0]        read_mux;

    // only the DAC word is writable, and only when bus control is enabled
    assign write_hit = mmi_req.wvalid && wready_q && en_mmi_ctrl
                    && (mmi_req.waddr == `DAC_ADDR_WORD);

    assign read_accept = mmi_req.arvalid && (!rvalid_q || mmi_req.rready);

    // gain replaces the data field, mode and reserved bits are kept
    always_comb begin
        gain_word             = dac_word_q;
        gain_word.fields.data = gain;
    end

    always_comb begin
        if (mmi_req.raddr >= `DAC_ADDR_W'(`DAC_NUM_REGS)) begin
            read_mux = 16'h0000;
        end else begin
            case (mmi_req.raddr)
                `DAC_ADDR_VERSION: read_mux = `DAC_MODULE_VERSION;
                `DAC_ADDR_WORD:    read_mux = dac_word_q.raw;
                default:           read_mux = {15'd0, en_q};
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // register updates and transfer requests

    always_ff @(posedge clk_ifc) begin
        if (SET_DEFAULT_ON_RESET) begin
            dac_word_q.raw <= `DAC_DEFAULT_WORD;
            en_q           <= 1'b0;
            req_stb_q      <= 1'b0;
        end else begin
            en_q      <= en_mmi_ctrl;
            req_stb_q <= write_hit || gain_stb;

            // a bus write wins over a gain strobe in the same cycle
            if (write_hit) begin
                dac_word_q.raw <= mmi_req.wdata;
                req_word_q.raw <= mmi_req.wdata;
            end else if (gain_stb) begin
                req_word_q <= gain_word;
                if (!en_mmi_ctrl) begin
                    dac_word_q <= gain_word;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // bus handshake

    always_ff @(posedge clk_ifc) begin
        if (SET_DEFAULT_ON_RESET) begin
            wready_q  <= 1'b0;
            arready_q <= 1'b0;
            rvalid_q  <= 1'b0;
        end else begin
            wready_q  <= 1'b1;
            arready_q <= 1'b0;
            if (read_accept) begin
                arready_q <= 1'b1;
                rvalid_q  <= 1'b1;
                rdata_q   <= read_mux;
            end else if (mmi_req.rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    assign mmi_rsp.wready  = wready_q;
    assign mmi_rsp.arready = arready_q;
    assign mmi_rsp.rvalid  = rvalid_q;
    assign mmi_rsp.rdata   = rdata_q;

    assign xfer_req.stb  = req_stb_q;
    assign xfer_req.word = req_word_q;

endmodule

`default_nettype wire

//--- src/dac_xfer_sequencer.sv
// DAC transfer sequencer
// sends the reset word, then launches requests with one pending slot while busy
`timescale 1ns/1ps
`default_nettype none

`include "dac_params.svh"

module dac_xfer_sequencer (
    input  var logic               clk_ifc,
    input  var logic               SET_DEFAULT_ON_RESET,
    input  var dac_pkg::dac_xfer_t xfer_req,
    output logic                   start,
    output dac_pkg::dac_word_u     tx_word,
    input  var logic               busy,
    input  var logic               done,
    output logic                   initdone,
    output logic                   dac_updated_stb
);

    typedef enum logic [1:0] {
        ST_DEFAULT,
        ST_IDLE,
        ST_ACTIVE
    } state_t;

    state_t             state;
    dac_pkg::dac_word_u pend_word;
    logic               pend_vld;
    logic               init_seen;

    // every finished frame is reported in the cycle done is seen
    assign dac_updated_stb = done && (state == ST_ACTIVE);
    assign initdone        = init_seen || dac_updated_stb;

    ////////////////////////////////////////////////////////////
    // launch control

    always_ff @(posedge clk_ifc) begin
        if (SET_DEFAULT_ON_RESET) begin
            state     <= ST_DEFAULT;
            start     <= 1'b0;
            pend_vld  <= 1'b0;
            init_seen <= 1'b0;
        end else begin
            start <= 1'b0;
            if (dac_updated_stb) begin
                init_seen <= 1'b1;
            end

            case (state)
                // first cycle out of reset
                ST_DEFAULT: begin
                    start       <= 1'b1;
                    tx_word.raw <= `DAC_DEFAULT_WORD;
                    state       <= ST_ACTIVE;
                    if (xfer_req.stb) begin
                        pend_word <= xfer_req.word;
                        pend_vld  <= 1'b1;
                    end
                end

                ST_IDLE: begin
                    if (xfer_req.stb) begin
                        state <= ST_ACTIVE;
                        if (busy) begin
                            // shifter still finishing, wait for its done
                            pend_word <= xfer_req.word;
                            pend_vld  <= 1'b1;
                        end else begin
                            start   <= 1'b1;
                            tx_word <= xfer_req.word;
                        end
                    end
                end

                ST_ACTIVE: begin
                    if (done) begin
                        // newest word wins, older pending one is dropped
                        if (xfer_req.stb) begin
                            start    <= 1'b1;
                            tx_word  <= xfer_req.word;
                            pend_vld <= 1'b0;
                        end else if (pend_vld) begin
                            start    <= 1'b1;
                            tx_word  <= pend_word;
                            pend_vld <= 1'b0;
                        end else begin
                            state <= ST_IDLE;
                        end
                    end else if (xfer_req.stb) begin
                        pend_word <= xfer_req.word;
                        pend_vld  <= 1'b1;
                    end
                end

                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/spi_shift_master.sv
// write-only SPI frame shifter
// shifts one 16-bit word MSB first, sclk idles high, DAC samples on the fall
`timescale 1ns/1ps
`default_nettype none

`include "dac_params.svh"

module spi_shift_master (
    input  var logic               clk_ifc,
    input  var logic               SET_DEFAULT_ON_RESET,
    input  var logic               start,
    input  var dac_pkg::dac_word_u tx_word,
    output logic                   busy,
    output logic                   done,
    output logic                   sclk,
    output logic                   sync_n,
    output logic                   sdin
);

    localparam int HALF  = `DAC_SCLK_HALF;
    localparam int DIV_W = $clog2(HALF + 1);

    logic [DIV_W-1:0] div_cnt;
    logic [4:0]       fall_cnt;
    // bits still to send after the one on sdin
    logic [14:0]      shreg;
    logic             half_end;

    assign half_end = (div_cnt == DIV_W'(HALF - 1));

    always_ff @(posedge clk_ifc) begin
        if (SET_DEFAULT_ON_RESET) begin
            busy     <= 1'b0;
            done     <= 1'b0;
            sclk     <= 1'b1;
            sync_n   <= 1'b1;
            sdin     <= 1'b0;
            div_cnt  <= '0;
            fall_cnt <= '0;
        end else begin
            done <= 1'b0;
            if (!busy) begin
                if (start) begin
                    // select drops with sclk high and the MSB already driven
                    busy     <= 1'b1;
                    sync_n   <= 1'b0;
                    sclk     <= 1'b1;
                    sdin     <= tx_word.raw[15];
                    shreg    <= tx_word.raw[14:0];
                    div_cnt  <= '0;
                    fall_cnt <= '0;
                end
            end else if (!half_end) begin
                div_cnt <= div_cnt + 1'b1;
            end else begin
                div_cnt <= '0;
                if (sclk) begin
                    sclk     <= 1'b0;
                    fall_cnt <= fall_cnt + 1'b1;
                end else if (fall_cnt == 5'd16) begin
                    // last low half over, close the frame
                    sclk   <= 1'b1;
                    sync_n <= 1'b1;
                    busy   <= 1'b0;
                    done   <= 1'b1;
                end else begin
                    // next bit goes out with the rising edge
                    sclk  <= 1'b1;
                    sdin  <= shreg[14];
                    shreg <= {shreg[13:0], 1'b0};
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- src/dac_ctrl_top.sv
// nanoDAC controller top level
// register map, transfer sequencer and SPI shifter
`timescale 1ns/1ps
`default_nettype none

module dac_ctrl_top (
    input  var logic              clk_ifc,
    input  var logic              SET_DEFAULT_ON_RESET,
    input  var mmi_pkg::mmi_req_t mmi_req,
    output mmi_pkg::mmi_rsp_t     mmi_rsp,
    input  var logic              en_mmi_ctrl,
    input  var logic [7:0]        gain,
    input  var logic              gain_stb,
    output logic                  sclk,
    output logic                  sync_n,
    output logic                  sdin,
    output logic                  initdone,
    output logic                  dac_updated_stb
);

    dac_pkg::dac_xfer_t xfer_req;
    dac_pkg::dac_word_u tx_word;
    logic               start;
    logic               busy;
    logic               done;

    dac_reg_map u_reg_map (
        .clk_ifc              (clk_ifc),
        .SET_DEFAULT_ON_RESET (SET_DEFAULT_ON_RESET),
        .mmi_req              (mmi_req),
        .mmi_rsp              (mmi_rsp),
        .en_mmi_ctrl          (en_mmi_ctrl),
        .gain                 (gain),
        .gain_stb             (gain_stb),
        .xfer_req             (xfer_req)
    );

    dac_xfer_sequencer u_sequencer (
        .clk_ifc              (clk_ifc),
        .SET_DEFAULT_ON_RESET (SET_DEFAULT_ON_RESET),
        .xfer_req             (xfer_req),
        .start                (start),
        .tx_word              (tx_word),
        .busy                 (busy),
        .done                 (done),
        .initdone             (initdone),
        .dac_updated_stb      (dac_updated_stb)
    );

    spi_shift_master u_spi (
        .clk_ifc              (clk_ifc),
        .SET_DEFAULT_ON_RESET (SET_DEFAULT_ON_RESET),
        .start                (start),
        .tx_word              (tx_word),
        .busy                 (busy),
        .done                 (done),
        .sclk                 (sclk),
        .sync_n               (sync_n),
        .sdin                 (sdin)
    );

endmodule

`default_nettype wire

//--- tests/tb_dac_ctrl.sv
// nanoDAC controller testbench
// drives the register bus and gain strobe, captures SPI frames and checks them
`timescale 1ns/1ps
`default_nettype none

`include "dac_params.svh"

module tb_dac_ctrl;

    localparam int CYCLE_LIMIT = 12 * 70 + 400;

    logic              clk_ifc;
    logic              SET_DEFAULT_ON_RESET;
    mmi_pkg::mmi_req_t mmi_req;
    mmi_pkg::mmi_rsp_t mmi_rsp;
    logic              en_mmi_ctrl;
    logic [7:0]        gain;
    logic              gain_stb;
    logic              sclk;
    logic              sync_n;
    logic              sdin;
    logic              initdone;
    logic              dac_updated_stb;

    int                err_seq = 0;
    int                err_mon = 0;
    int                err_prop = 0;
    int                cycles = 0;
    int                nframes = 0;
    int                falls = 0;
    logic              in_frame = 1'b0;
    logic              frame_end;
    logic              sclk_d;
    logic              sync_n_d;
    logic [15:0]       frame_sr;
    logic [15:0]       captured_q[$];
    logic [15:0]       model_word;
    logic [31:0]       rng = 32'h1f5f;

    dac_ctrl_top uut (
        .clk_ifc              (clk_ifc),
        .SET_DEFAULT_ON_RESET (SET_DEFAULT_ON_RESET),
        .mmi_req              (mmi_req),
        .mmi_rsp              (mmi_rsp),
        .en_mmi_ctrl          (en_mmi_ctrl),
        .gain                 (gain),
        .gain_stb             (gain_stb),
        .sclk                 (sclk),
        .sync_n               (sync_n),
        .sdin                 (sdin),
        .initdone             (initdone),
        .dac_updated_stb      (dac_updated_stb)
    );

    initial clk_ifc = 1'b0;
    always #20 clk_ifc = ~clk_ifc;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        assert (got == exp)
        else begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            err_seq++;
        end
    endtask

    task automatic check_true(input string what, input logic cond);
        assert (cond)
        else begin
            $display("Check failed: %s", what);
            err_seq++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // bus and strobe drivers

    task automatic send_write(input logic [15:0] data);
        @(posedge clk_ifc);
        mmi_req.wvalid <= 1'b1;
        mmi_req.waddr  <= `DAC_ADDR_WORD;
        mmi_req.wdata  <= data;
        @(posedge clk_ifc);
        // wready stays high once out of reset
        check_value("wready", {15'd0, mmi_rsp.wready}, 16'h0001);
        mmi_req.wvalid <= 1'b0;
        // writes only land while bus control is on
        if (en_mmi_ctrl) begin
            model_word = data;
        end
    endtask

    task automatic send_gain(input logic [7:0] g, output logic [15:0] word);
        @(posedge clk_ifc);
        gain     <= g;
        gain_stb <= 1'b1;
        word = {model_word[15:14], g, model_word[5:0]};
        if (!en_mmi_ctrl) begin
            model_word = word;
        end
        @(posedge clk_ifc);
        gain_stb <= 1'b0;
    endtask

    task automatic read_reg(input logic [1:0] addr, input logic [15:0] exp,
                            input string name);
        @(posedge clk_ifc);
        mmi_req.arvalid <= 1'b1;
        mmi_req.raddr   <= addr;
        mmi_req.rready  <= 1'b0;
        @(posedge clk_ifc);
        while (!mmi_rsp.rvalid) begin
            @(posedge clk_ifc);
        end
        check_value("arready", {15'd0, mmi_rsp.arready}, 16'h0001);
        mmi_req.arvalid <= 1'b0;
        // response must wait for rready
        repeat (2) begin
            @(posedge clk_ifc);
            check_value("rvalid", {15'd0, mmi_rsp.rvalid}, 16'h0001);
        end
        mmi_req.rready <= 1'b1;
        check_value(name, mmi_rsp.rdata, exp);
        @(posedge clk_ifc);
        mmi_req.rready <= 1'b0;
    endtask

    task automatic expect_frame(input logic [15:0] exp);
        while (captured_q.size() == 0) begin
            @(posedge clk_ifc);
        end
        check_value("sdin frame", captured_q.pop_front(), exp);
    endtask

    ////////////////////////////////////////////////////////////
    // SPI monitor, frame-end checks and cycle limit

    always @(posedge clk_ifc) begin
        frame_end = 1'b0;
        cycles++;
        if (SET_DEFAULT_ON_RESET) begin
            in_frame = 1'b0;
        end else begin
            if (sync_n_d && !sync_n) begin
                in_frame = 1'b1;
                falls    = 0;
            end
            // the DAC takes sdin on the falling edge of sclk
            if (in_frame && !sync_n && sclk_d && !sclk) begin
                frame_sr = {frame_sr[14:0], sdin};
                falls++;
            end
            if (in_frame && !sync_n_d && sync_n) begin
                in_frame  = 1'b0;
                frame_end = 1'b1;
                nframes++;
                captured_q.push_back(frame_sr);
                assert (falls == 16)
                else begin
                    $display("frame ended after %0d sclk falling edges, not 16", falls);
                    err_mon++;
                end
            end
            assert (dac_updated_stb == frame_end)
            else begin
                $display("Mismatch dac_updated_stb: got %h expected %h",
                         dac_updated_stb, frame_end);
                err_mon++;
            end
            assert (initdone == (nframes > 0))
            else begin
                $display("Mismatch initdone: got %h expected %h", initdone, nframes > 0);
                err_mon++;
            end
        end
        sclk_d   = sclk;
        sync_n_d = sync_n;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the test did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TB FAILED");
            $finish;
        end
    end

    sync_falls_with_sclk_high: assert property (
        @(posedge clk_ifc) disable iff (SET_DEFAULT_ON_RESET) $fell(sync_n) |-> sclk
    ) else begin
        $display("sync_n fell while sclk was low");
        err_prop++;
    end

    ////////////////////////////////////////////////////////////
    // test sequence

    initial begin
        logic [15:0] word;
        SET_DEFAULT_ON_RESET <= 1'b1;
        mmi_req              <= '0;
        en_mmi_ctrl          <= 1'b0;
        gain                 <= 8'h00;
        gain_stb             <= 1'b0;
        model_word = `DAC_DEFAULT_WORD;
        repeat (8) @(posedge clk_ifc);
        SET_DEFAULT_ON_RESET <= 1'b0;

        // reset word first, then the read-only registers
        expect_frame(`DAC_DEFAULT_WORD);
        read_reg(`DAC_ADDR_VERSION, `DAC_MODULE_VERSION, "rdata version");
        read_reg(`DAC_ADDR_WORD, model_word, "rdata dac word");
        read_reg(`DAC_ADDR_EN, 16'h0000, "rdata enable");
        read_reg(2'd3, 16'h0000, "rdata unmapped");

        en_mmi_ctrl <= 1'b1;
        send_write(16'hb5a5);
        expect_frame(16'hb5a5);
        read_reg(`DAC_ADDR_WORD, model_word, "rdata dac word");
        read_reg(`DAC_ADDR_EN, 16'h0001, "rdata enable");

        // with bus control off a write is dropped
        en_mmi_ctrl <= 1'b0;
        send_write(16'h1234);
        repeat (100) @(posedge clk_ifc);
        check_true("a frame was sent for a write with bus control off",
                   captured_q.size() == 0);
        read_reg(`DAC_ADDR_WORD, model_word, "rdata dac word");

        rng = xorshift32(rng);
        send_gain(rng[7:0], word);
        expect_frame(word);
        read_reg(`DAC_ADDR_WORD, model_word, "rdata dac word");

        en_mmi_ctrl <= 1'b1;
        rng = xorshift32(rng);
        send_gain(rng[7:0], word);
        expect_frame(word);
        read_reg(`DAC_ADDR_WORD, model_word, "rdata dac word");

        // requests during a frame collapse into one more frame
        send_write(16'h3c80);
        while (sync_n) begin
            @(posedge clk_ifc);
        end
        send_write(16'hc3c3);
        send_write(16'h5a40);
        rng = xorshift32(rng);
        send_gain(rng[7:0], word);
        expect_frame(16'h3c80);
        expect_frame(word);
        repeat (150) @(posedge clk_ifc);
        check_true("an extra frame followed the queued requests", captured_q.size() == 0);

        $display("errors: sequence %0d, monitor %0d, protocol %0d; frames %0d",
                 err_seq, err_mon, err_prop, nframes);
        if (err_seq + err_mon + err_prop == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+src
src/mmi_pkg.sv
src/dac_pkg.sv
src/dac_reg_map.sv
src/dac_xfer_sequencer.sv
src/spi_shift_master.sv
src/dac_ctrl_top.sv
tests/tb_dac_ctrl.sv

//--- run.sh
#!/bin/sh
# build and run the nanoDAC controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_dac_ctrl \
    -f build.f \
    -o tb_dac_ctrl

out=$(./obj_dir/tb_dac_ctrl)
echo "$out"

if echo "$out" | grep -qx "TB PASSED"; then
    exit 0
else
    exit 1
fi
